//--- compile.f
rtl/mmu_pkg.sv
rtl/tlb_array.sv
rtl/tlb_write_arbiter.sv
rtl/table_walker.sv
rtl/asid_flush_sweeper.sv
rtl/mmu_top.sv
verification/tb_page_memory.sv
verification/tb_mmu_top.sv

//--- rtl/asid_flush_sweeper.sv
/* ASID flush sweeper */
`timescale 1ns/10ps

module asid_flush_sweeper (
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic                          flush_i,
	input  logic [mmu_pkg::ASID_W-1:0]    flush_asid_i,
	// Sweep read
	output logic [mmu_pkg::TLB_ABITS-1:0] sweep_idx_o,
	input  mmu_pkg::tlb_entry_t           sweep_entry_i,
	// TLB write request
	output logic                          sw_req_o,
	output logic [mmu_pkg::TLB_ABITS-1:0] sw_idx_o,
	output mmu_pkg::tlb_entry_t           sw_entry_o,
	input  logic                          sw_gnt_i,
	output logic                          flush_busy_o,
	output logic                          flush_done_o
);
	import mmu_pkg::*;

	logic [TLB_ABITS-1:0] idx_q;
	logic [ASID_W-1:0]    asid_q;
	logic                 match;
	logic                 step;

	assign match = sweep_entry_i.valid && !sweep_entry_i.global
		&& (sweep_entry_i.asid == asid_q);

	// Invalidate a match, otherwise move on at once
	assign sw_req_o = flush_busy_o && match;
	assign step     = flush_busy_o && (!match || sw_gnt_i);

	assign sweep_idx_o = idx_q;
	assign sw_idx_o    = idx_q;

	always_comb begin
		sw_entry_o = sweep_entry_i;
		sw_entry_o.valid = 1'b0;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flush_busy_o <= 1'b0;
			flush_done_o <= 1'b0;
			idx_q        <= '0;
		end else begin
			flush_done_o <= 1'b0;
			if (!flush_busy_o) begin
				if (flush_i) begin
					flush_busy_o <= 1'b1;
					idx_q        <= '0;
				end
			end else if (step) begin
				if (idx_q == TLB_ABITS'(TLB_ENTRIES - 1)) begin
					flush_busy_o <= 1'b0;
					flush_done_o <= 1'b1;
				end
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (flush_i && !flush_busy_o) begin
			asid_q <= flush_asid_i;
		end
	end

endmodule

//--- rtl/mmu_pkg.sv
/* MMU shared definitions */
package mmu_pkg;

	// ========================================
	// Widths and counts
	// ========================================
	localparam int ADR_W        = 32;
	localparam int ASID_W       = 8;
	localparam int LOG_PAGESIZE = 12;
	localparam int TLB_ENTRIES  = 16;
	localparam int TLB_ABITS    = $clog2(TLB_ENTRIES);
	localparam int PTE_W        = 32;
	localparam int PPN_W        = 20;
	localparam int VPN_TAG_W    = ADR_W - LOG_PAGESIZE - TLB_ABITS;

	// ========================================
	// Page-table index fields
	// ========================================
	localparam int LEV1_LSB  = 22;
	localparam int LEV2_LSB  = 12;
	localparam int LEV_IDX_W = 10;
	localparam int PTE_BYTES = 4;

	// ========================================
	// Page-table word and TLB entry
	// ========================================

	// Leaf entry, the level-2 view
	typedef struct packed {
		logic             v;
		logic             g;
		logic             typ;
		logic [8:0]       rsvd;
		logic [PPN_W-1:0] ppn;
	} pte_leaf_t;

	// Pointer to the next table, the level-1 view
	// Bit 30 holds the global flag of a leaf and means nothing here
	typedef struct packed {
		logic             v;
		logic             rsvd_hi;
		logic             typ;
		logic [8:0]       rsvd_lo;
		logic [PPN_W-1:0] next_ppn;
	} pte_ptr_t;

	typedef union packed {
		pte_leaf_t leaf;
		pte_ptr_t  ptr;
	} pte_word_u;

	typedef struct packed {
		logic                 valid;
		logic                 global;
		logic [ASID_W-1:0]    asid;
		logic [VPN_TAG_W-1:0] vpn_tag;
		logic [PPN_W-1:0]     ppn;
	} tlb_entry_t;

endpackage

//--- rtl/mmu_top.sv
/* MMU top level */
`timescale 1ns/10ps

module mmu_top (
	input  logic                       clk,
	input  logic                       arst_n_i,
	// Lookup
	input  logic [mmu_pkg::ADR_W-1:0]  vadr_i,
	input  logic                       vadr_v_i,
	input  logic [mmu_pkg::ASID_W-1:0] asid_i,
	output logic [mmu_pkg::ADR_W-1:0]  padr_o,
	output logic                       padr_v_o,
	output logic                       miss_o,
	// Walk control
	input  logic [mmu_pkg::ADR_W-1:0]  ptbr_i,
	input  logic                       clear_fault_i,
	output logic                       page_fault_o,
	// Memory read bus
	output logic                       mem_req_o,
	output logic [mmu_pkg::ADR_W-1:0]  mem_adr_o,
	input  logic                       mem_ack_i,
	input  logic [mmu_pkg::PTE_W-1:0]  mem_dat_i,
	// Flush
	input  logic                       flush_i,
	input  logic [mmu_pkg::ASID_W-1:0] flush_asid_i,
	output logic                       flush_busy_o,
	output logic                       flush_done_o
);
	import mmu_pkg::*;

	logic                 hit;
	logic [PPN_W-1:0]     hit_ppn;
	logic [TLB_ABITS-1:0] sweep_idx;
	tlb_entry_t           sweep_entry;
	logic                 wk_req, wk_gnt, sw_req, sw_gnt, wr_en;
	logic [TLB_ABITS-1:0] wk_idx, sw_idx, wr_idx;
	tlb_entry_t           wk_entry, sw_entry, wr_entry;
	logic                 walk_busy;

	tlb_array u_tlb_array (
		.clk(clk), .arst_n_i(arst_n_i),
		.vadr_i(vadr_i), .asid_i(asid_i), .hit_o(hit), .hit_ppn_o(hit_ppn),
		.sweep_idx_i(sweep_idx), .sweep_entry_o(sweep_entry),
		.wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_entry_i(wr_entry)
	);

	tlb_write_arbiter u_tlb_write_arbiter (
		.clk(clk), .arst_n_i(arst_n_i),
		.wk_req_i(wk_req), .wk_idx_i(wk_idx), .wk_entry_i(wk_entry), .wk_gnt_o(wk_gnt),
		.sw_req_i(sw_req), .sw_idx_i(sw_idx), .sw_entry_i(sw_entry), .sw_gnt_o(sw_gnt),
		.wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_entry_o(wr_entry)
	);

	table_walker u_table_walker (
		.clk(clk), .arst_n_i(arst_n_i),
		.miss_i(miss_o), .vadr_i(vadr_i), .asid_i(asid_i), .ptbr_i(ptbr_i),
		.clear_fault_i(clear_fault_i),
		.mem_req_o(mem_req_o), .mem_adr_o(mem_adr_o),
		.mem_ack_i(mem_ack_i), .mem_dat_i(mem_dat_i),
		.wk_req_o(wk_req), .wk_idx_o(wk_idx), .wk_entry_o(wk_entry), .wk_gnt_i(wk_gnt),
		.busy_o(walk_busy), .page_fault_o(page_fault_o)
	);

	asid_flush_sweeper u_asid_flush_sweeper (
		.clk(clk), .arst_n_i(arst_n_i),
		.flush_i(flush_i), .flush_asid_i(flush_asid_i),
		.sweep_idx_o(sweep_idx), .sweep_entry_i(sweep_entry),
		.sw_req_o(sw_req), .sw_idx_o(sw_idx), .sw_entry_o(sw_entry), .sw_gnt_i(sw_gnt),
		.flush_busy_o(flush_busy_o), .flush_done_o(flush_done_o)
	);

	// ========================================
	// Lookup result register
	// ========================================

	// No new miss while a walk runs or a fault waits to be cleared
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			padr_v_o <= 1'b0;
			miss_o   <= 1'b0;
		end else begin
			padr_v_o <= vadr_v_i & hit;
			miss_o   <= vadr_v_i & ~hit & ~walk_busy & ~page_fault_o;
		end
	end

	always_ff @(posedge clk) begin
		padr_o <= {hit_ppn, vadr_i[LOG_PAGESIZE-1:0]};
	end

endmodule

//--- rtl/table_walker.sv
/* Two-level page-table walker */
`timescale 1ns/10ps

module table_walker (
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic                          miss_i,
	input  logic [mmu_pkg::ADR_W-1:0]     vadr_i,
	input  logic [mmu_pkg::ASID_W-1:0]    asid_i,
	input  logic [mmu_pkg::ADR_W-1:0]     ptbr_i,
	input  logic                          clear_fault_i,
	// Memory read bus
	output logic                          mem_req_o,
	output logic [mmu_pkg::ADR_W-1:0]     mem_adr_o,
	input  logic                          mem_ack_i,
	input  logic [mmu_pkg::PTE_W-1:0]     mem_dat_i,
	// TLB write request
	output logic                          wk_req_o,
	output logic [mmu_pkg::TLB_ABITS-1:0] wk_idx_o,
	output mmu_pkg::tlb_entry_t           wk_entry_o,
	input  logic                          wk_gnt_i,
	output logic                          busy_o,
	output logic                          page_fault_o
);
	import mmu_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_rd_lev1,
		st_rd_lev2,
		st_write,
		st_fault
	} walk_state_t;

	walk_state_t          state;
	logic [ADR_W-1:0]     miss_vadr;
	logic [ASID_W-1:0]    miss_asid;
	logic [LEV_IDX_W-1:0] lev1_idx;
	logic [LEV_IDX_W-1:0] lev2_idx;
	pte_word_u            pte;
	tlb_entry_t           new_entry;
	logic                 start;
	logic                 lev1_ack;
	logic                 lev2_ack;
	logic                 lev1_ok;

	assign lev1_idx = vadr_i[LEV1_LSB +: LEV_IDX_W];
	assign lev2_idx = miss_vadr[LEV2_LSB +: LEV_IDX_W];

	// One word, read as a pointer at level 1 and as a leaf at level 2
	assign pte = mem_dat_i;
	assign lev1_ok = pte.ptr.v && pte.ptr.typ;

	assign start    = (state == st_idle) && miss_i;
	assign lev1_ack = (state == st_rd_lev1) && mem_req_o && mem_ack_i;
	assign lev2_ack = (state == st_rd_lev2) && mem_req_o && mem_ack_i;

	always_comb begin
		new_entry.valid   = 1'b1;
		new_entry.global  = pte.leaf.g;
		new_entry.asid    = miss_asid;
		new_entry.vpn_tag = miss_vadr[ADR_W-1 -: VPN_TAG_W];
		new_entry.ppn     = pte.leaf.ppn;
	end

	// ========================================
	// Walk FSM
	// ========================================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state        <= st_idle;
			mem_req_o    <= 1'b0;
			page_fault_o <= 1'b0;
		end else begin
			case (state)
			st_idle:
				if (miss_i) begin
					mem_req_o <= 1'b1;
					state     <= st_rd_lev1;
				end
			st_rd_lev1:
				if (lev1_ack) begin
					mem_req_o <= 1'b0;
					if (lev1_ok) begin
						state <= st_rd_lev2;
					end else begin
						page_fault_o <= 1'b1;
						state        <= st_fault;
					end
				end
			st_rd_lev2:
				// Request stays low for the first cycle here
				if (!mem_req_o) begin
					mem_req_o <= 1'b1;
				end else if (lev2_ack) begin
					mem_req_o <= 1'b0;
					if (pte.leaf.v) begin
						state <= st_write;
					end else begin
						page_fault_o <= 1'b1;
						state        <= st_fault;
					end
				end
			st_write:
				if (wk_gnt_i) begin
					state <= st_idle;
				end
			st_fault:
				if (clear_fault_i) begin
					page_fault_o <= 1'b0;
					state        <= st_idle;
				end
			default:
				state <= st_idle;
			endcase
		end
	end

	// Address and entry payload
	always_ff @(posedge clk) begin
		if (start) begin
			miss_vadr <= vadr_i;
			miss_asid <= asid_i;
			mem_adr_o <= ptbr_i + ADR_W'(lev1_idx) * PTE_BYTES;
		end
		if (lev1_ack) begin
			mem_adr_o <= {pte.ptr.next_ppn, {LOG_PAGESIZE{1'b0}}} + ADR_W'(lev2_idx) * PTE_BYTES;
		end
		if (lev2_ack) begin
			wk_entry_o <= new_entry;
		end
	end

	assign wk_req_o = (state == st_write);
	assign wk_idx_o = miss_vadr[LOG_PAGESIZE +: TLB_ABITS];
	assign busy_o   = (state != st_idle);

	// A read request is held until memory answers it
	a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_req_o && !mem_ack_i |=> mem_req_o);

endmodule

//--- rtl/tlb_array.sv
/* Direct-mapped TLB store */
`timescale 1ns/10ps

module tlb_array (
	input  logic                          clk,
	input  logic                          arst_n_i,
	// Lookup
	input  logic [mmu_pkg::ADR_W-1:0]     vadr_i,
	input  logic [mmu_pkg::ASID_W-1:0]    asid_i,
	output logic                          hit_o,
	output logic [mmu_pkg::PPN_W-1:0]     hit_ppn_o,
	// Sweep read
	input  logic [mmu_pkg::TLB_ABITS-1:0] sweep_idx_i,
	output mmu_pkg::tlb_entry_t           sweep_entry_o,
	// Write port
	input  logic                          wr_en_i,
	input  logic [mmu_pkg::TLB_ABITS-1:0] wr_idx_i,
	input  mmu_pkg::tlb_entry_t           wr_entry_i
);
	import mmu_pkg::*;

	logic [TLB_ENTRIES-1:0] valid_q;
	tlb_entry_t             entry_mem [TLB_ENTRIES];
	logic [TLB_ABITS-1:0]   lk_idx;
	tlb_entry_t             lk_entry;
	logic                   tag_match;
	logic                   asid_match;

	// ========================================
	// Storage
	// ========================================

	// Valid bits live apart so reset can clear them
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else if (wr_en_i) begin
			valid_q[wr_idx_i] <= wr_entry_i.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			entry_mem[wr_idx_i] <= wr_entry_i;
		end
	end

	// ========================================
	// Lookup compare
	// ========================================
	assign lk_idx = vadr_i[LOG_PAGESIZE +: TLB_ABITS];

	always_comb begin
		lk_entry = entry_mem[lk_idx];
		lk_entry.valid = valid_q[lk_idx];
	end

	assign tag_match = (lk_entry.vpn_tag == vadr_i[ADR_W-1 -: VPN_TAG_W]);
	// Global pages match under any ASID
	assign asid_match = lk_entry.global || (lk_entry.asid == asid_i);
	assign hit_o = lk_entry.valid && tag_match && asid_match;
	assign hit_ppn_o = lk_entry.ppn;

	// Sweep port reads the same store
	always_comb begin
		sweep_entry_o = entry_mem[sweep_idx_i];
		sweep_entry_o.valid = valid_q[sweep_idx_i];
	end

	// Write index must be known and inside the store
	a_wr_idx_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_en_i |-> !$isunknown(wr_idx_i) && (int'(wr_idx_i) < TLB_ENTRIES));

endmodule

//--- rtl/tlb_write_arbiter.sv
/* TLB write port arbiter */
`timescale 1ns/10ps

module tlb_write_arbiter (
	input  logic                          clk,
	input  logic                          arst_n_i,
	// Walker side
	input  logic                          wk_req_i,
	input  logic [mmu_pkg::TLB_ABITS-1:0] wk_idx_i,
	input  mmu_pkg::tlb_entry_t           wk_entry_i,
	output logic                          wk_gnt_o,
	// Sweeper side
	input  logic                          sw_req_i,
	input  logic [mmu_pkg::TLB_ABITS-1:0] sw_idx_i,
	input  mmu_pkg::tlb_entry_t           sw_entry_i,
	output logic                          sw_gnt_o,
	// To the array
	output logic                          wr_en_o,
	output logic [mmu_pkg::TLB_ABITS-1:0] wr_idx_o,
	output mmu_pkg::tlb_entry_t           wr_entry_o
);

	// Walker first, the sweeper waits while a refill is pending
	assign wk_gnt_o = wk_req_i;
	assign sw_gnt_o = sw_req_i & ~wk_req_i;

	// The write lands on the edge that ends the granted cycle
	assign wr_en_o    = wk_gnt_o | sw_gnt_o;
	assign wr_idx_o   = wk_gnt_o ? wk_idx_i : sw_idx_i;
	assign wr_entry_o = wk_gnt_o ? wk_entry_i : sw_entry_i;

	// ========================================
	// Checks
	// ========================================
	a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0({wk_gnt_o, sw_gnt_o}));

	a_wk_gnt_own_req: assert property (@(posedge clk) disable iff (!arst_n_i)
		wk_gnt_o |-> wk_req_i);

	a_sw_gnt_own_req: assert property (@(posedge clk) disable iff (!arst_n_i)
		sw_gnt_o |-> sw_req_i);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mmu_top -f compile.f -Mdir obj_dir -o tb_mmu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_mmu_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

//--- verification/tb_mmu_top.sv
/* MMU testbench */
`timescale 1ns/10ps

module tb_mmu_top;

	typedef enum int {op_lookup, op_clear, op_flush} op_t;

	localparam int          NUM_ROWS   = 14;
	localparam int          WAIT_LIMIT = 200;
	localparam logic [31:0] PT_BASE    = 32'h0001_0000;

	logic        clk;
	logic        arst_n_i;
	logic [31:0] vadr_i;
	logic        vadr_v_i;
	logic [7:0]  asid_i;
	logic [31:0] padr_o;
	logic        padr_v_o;
	logic        miss_o;
	logic [31:0] ptbr_i;
	logic        clear_fault_i;
	logic        page_fault_o;
	logic        mem_req_o;
	logic [31:0] mem_adr_o;
	logic        mem_ack_i;
	logic [31:0] mem_dat_i;
	logic        flush_i;
	logic [7:0]  flush_asid_i;
	logic        flush_busy_o;
	logic        flush_done_o;

	// Stimulus and expectation table
	string       row_name  [NUM_ROWS];
	op_t         row_op    [NUM_ROWS];
	logic [31:0] row_vadr  [NUM_ROWS];
	logic [7:0]  row_asid  [NUM_ROWS];
	logic        row_miss  [NUM_ROWS];
	logic        row_fault [NUM_ROWS];
	logic [31:0] row_padr  [NUM_ROWS];
	int          row_count;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	mmu_top UUT (.*);

	tb_page_memory #(.PT_BASE(PT_BASE)) u_page_memory (
		.clk(clk), .arst_n_i(arst_n_i),
		.mem_req_i(mem_req_o), .mem_adr_i(mem_adr_o),
		.mem_ack_o(mem_ack_i), .mem_dat_o(mem_dat_i)
	);

	always #2 clk = ~clk;

	task automatic add_row(input string name, input op_t op, input logic [31:0] vadr,
		input logic [7:0] asid, input logic miss, input logic fault, input logic [31:0] padr);
		row_name[row_count]  = name;
		row_op[row_count]    = op;
		row_vadr[row_count]  = vadr;
		row_asid[row_count]  = asid;
		row_miss[row_count]  = miss;
		row_fault[row_count] = fault;
		row_padr[row_count]  = padr;
		row_count++;
	endtask

	// ========================================
	// Test table
	// ========================================
	task automatic fill_table();
		// Identity map by rule: ppn = (l1 index << 10) + l2 index
		add_row("first_lookup",     op_lookup, 32'h0080_3123, 8'd3, 1, 0, 32'h0080_3123);
		add_row("repeat_lookup",    op_lookup, 32'h0080_3123, 8'd3, 0, 0, 32'h0080_3123);
		add_row("second_index",     op_lookup, 32'h0100_A0AC, 8'd3, 1, 0, 32'h0100_A0AC);
		add_row("asid5_entry",      op_lookup, 32'h0180_67F0, 8'd5, 1, 0, 32'h0180_67F0);
		add_row("odd_lev1_fault",   op_lookup, 32'h00C0_1000, 8'd3, 1, 1, 32'h0);
		add_row("clear_lev1_fault", op_clear,  32'h0,         8'd0, 0, 0, 32'h0);
		add_row("lev2_fault",       op_lookup, 32'h0080_E010, 8'd3, 1, 1, 32'h0);
		add_row("clear_lev2_fault", op_clear,  32'h0,         8'd0, 0, 0, 32'h0);
		add_row("lev2_fault_asid5", op_lookup, 32'h0080_E010, 8'd5, 1, 1, 32'h0);
		add_row("clear_asid5_fault", op_clear, 32'h0,         8'd0, 0, 0, 32'h0);
		add_row("flush_asid3",      op_flush,  32'h0,         8'd3, 0, 0, 32'h0);
		add_row("flushed_refill",   op_lookup, 32'h0080_3123, 8'd3, 1, 0, 32'h0080_3123);
		add_row("global_kept",      op_lookup, 32'h0100_A0AC, 8'd3, 0, 0, 32'h0100_A0AC);
		// Untouched ASID-5 entry survives the flush
		add_row("asid5_kept",       op_lookup, 32'h0180_67F0, 8'd5, 0, 0, 32'h0180_67F0);
	endtask

	task automatic run_lookup(input int k);
		int          cycles;
		logic        saw_miss;
		logic        saw_padr;
		logic        saw_fault;
		logic [31:0] got_padr;
		cycles    = 0;
		saw_miss  = 1'b0;
		saw_padr  = 1'b0;
		saw_fault = 1'b0;
		got_padr  = 32'h0;
		@(posedge clk);
		vadr_i   <= row_vadr[k];
		asid_i   <= row_asid[k];
		vadr_v_i <= 1'b1;
		while (!saw_padr && !saw_fault && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (miss_o)
				saw_miss = 1'b1;
			if (padr_v_o) begin
				saw_padr = 1'b1;
				got_padr = padr_o;
			end
			if (page_fault_o)
				saw_fault = 1'b1;
		end
		@(posedge clk);
		vadr_v_i <= 1'b0;
		if (!saw_padr && !saw_fault) begin
			$display("%s: no translation and no page fault within %0d cycles",
				row_name[k], WAIT_LIMIT);
			test_errs++;
		end
		if (saw_miss !== row_miss[k]) begin
			$display("[FAIL] %s: miss expected %0b, actual %0b", row_name[k], row_miss[k], saw_miss);
			test_errs++;
		end
		if (saw_fault !== row_fault[k]) begin
			$display("[FAIL] %s: page fault expected %0b, actual %0b",
				row_name[k], row_fault[k], saw_fault);
			test_errs++;
		end
		if (row_fault[k] && saw_padr) begin
			$display("%s: padr_v_o rose for an address that should fault", row_name[k]);
			test_errs++;
		end
		if (!row_fault[k] && saw_padr && got_padr !== row_padr[k]) begin
			$display("[FAIL] %s: padr expected %h, actual %h", row_name[k], row_padr[k], got_padr);
			test_errs++;
		end
	endtask

	task automatic run_clear(input int k);
		int   cycles;
		logic cleared;
		cycles  = 0;
		cleared = 1'b0;
		@(posedge clk);
		clear_fault_i <= 1'b1;
		@(posedge clk);
		clear_fault_i <= 1'b0;
		while (!cleared && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (!page_fault_o)
				cleared = 1'b1;
		end
		if (!cleared) begin
			$display("%s: page fault still set %0d cycles after the clear", row_name[k], WAIT_LIMIT);
			test_errs++;
		end
	endtask

	task automatic run_flush(input int k);
		int   cycles;
		logic saw_busy;
		logic saw_done;
		cycles   = 0;
		saw_busy = 1'b0;
		saw_done = 1'b0;
		@(posedge clk);
		flush_i      <= 1'b1;
		flush_asid_i <= row_asid[k];
		@(posedge clk);
		flush_i <= 1'b0;
		while (!saw_done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (flush_busy_o)
				saw_busy = 1'b1;
			if (flush_done_o)
				saw_done = 1'b1;
		end
		if (!saw_done) begin
			$display("%s: flush did not finish within %0d cycles", row_name[k], WAIT_LIMIT);
			test_errs++;
		end
		if (!saw_busy || flush_busy_o) begin
			$display("%s: flush_busy_o did not rise and fall around the sweep", row_name[k]);
			test_errs++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d error(s)", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int k;
		clk           = 1'b0;
		arst_n_i      = 1'b0;
		vadr_i        = 32'h0;
		vadr_v_i      = 1'b0;
		asid_i        = 8'h0;
		ptbr_i        = PT_BASE;
		clear_fault_i = 1'b0;
		flush_i       = 1'b0;
		flush_asid_i  = 8'h0;
		row_count     = 0;
		test_errs     = 0;
		tests_run     = 0;
		tests_failed  = 0;
		void'($urandom(32'h99277ae2));
		fill_table();

		repeat (3) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		if ({padr_v_o, miss_o, page_fault_o, mem_req_o, flush_busy_o} !== 5'b0) begin
			$display("[FAIL] reset_state: outputs expected %b, actual %b", 5'b0,
				{padr_v_o, miss_o, page_fault_o, mem_req_o, flush_busy_o});
			test_errs++;
		end
		report_test("reset_state");

		for (k = 0; k < row_count; k++) begin
			case (row_op[k])
			op_lookup: run_lookup(k);
			op_clear:  run_clear(k);
			default:   run_flush(k);
			endcase
			report_test(row_name[k]);
		end

		$display("Tests run: %0d, passed: %0d, failed: %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- verification/tb_page_memory.sv
/* Page-table memory model */
`timescale 1ns/10ps

module tb_page_memory #(
	parameter logic [31:0] PT_BASE = 32'h0001_0000
) (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        mem_req_i,
	input  logic [31:0] mem_adr_i,
	output logic        mem_ack_o,
	output logic [31:0] mem_dat_o
);

	logic        ack_q;
	logic [31:0] dat_q;
	logic        armed;
	logic [1:0]  wait_cnt;

	// Level-1 table at PT_BASE, level-2 table i on page 0x100 + i
	function automatic logic [31:0] word_at(input logic [31:0] adr);
		logic [19:0] page;
		logic [9:0]  tbl;
		logic [9:0]  slot;
		page = adr[31:12];
		slot = adr[11:2];
		if (page == PT_BASE[31:12]) begin
			// Odd level-1 slots are invalid
			if (slot[0])
				return 32'h0;
			return {1'b1, 1'b0, 1'b1, 9'd0, 20'h100 + 20'(slot)};
		end
		if (page < 20'h100 || page > 20'h4ff)
			return 32'h0;
		tbl = 10'(page - 20'h100);
		if (slot % 10'd7 == 10'd0)
			return 32'h0;
		return {1'b1, (slot % 10'd5 == 10'd0), 1'b0, 9'd0, tbl, slot};
	endfunction

	// Answer each request after 0 to 3 extra cycles
	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q    <= 1'b0;
			dat_q    <= 32'h0;
			armed    <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			ack_q <= 1'b0;
			if (mem_req_i && !ack_q) begin
				if (!armed) begin
					armed    <= 1'b1;
					wait_cnt <= 2'($urandom_range(3, 0));
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					armed <= 1'b0;
					ack_q <= 1'b1;
					dat_q <= word_at(mem_adr_i);
				end
			end
		end
	end

	// Bus stays quiet while reset is low
	assign mem_ack_o = ack_q & arst_n_i;
	assign mem_dat_o = arst_n_i ? dat_q : 32'h0;

endmodule
